//--- verilog/uart_bridge_cfg.svh
`ifndef UART_BRIDGE_CFG_SVH
`define UART_BRIDGE_CFG_SVH

// **************************************************
// Bridge defaults
// **************************************************

// Host command word: wr flag, 7-bit address, data byte
`define CMD_WIDTH 16

// Clock cycles per bit
`define DIV_RESET 16'd434

// Idle bit times between address and data frame of a write
`define GAP_RESET 8'd10

// Bit times to wait for a read reply
`define TMO_RESET 8'd40

`endif

//--- verilog/uart_pkg.sv
package uart_pkg;

  // Sense of the parity bit over data plus parity
  typedef enum logic
  {
    PAR_EVEN = 1'b0,
    PAR_ODD  = 1'b1
  } parity_t;

  // Which part of the 11-bit frame is on the line
  typedef enum logic [1:0]
  {
    START  = 2'd0,
    DATA   = 2'd1,
    PARITY = 2'd2,
    STOP   = 2'd3
  } frame_phase_t;

  // Parity bit that makes the total ones count match the sense
  function automatic logic calc_parity(input logic [7:0] value, input parity_t sense);
    return (^value) ^ sense;
  endfunction

endpackage

//--- verilog/cmd_pkg.sv
package cmd_pkg;

  // Bit of the command word that selects write
  localparam int CMD_WR_BIT = 15;

  typedef enum logic [2:0]
  {
    IDLE       = 3'd0,
    SEND_ADDR  = 3'd1,
    GAP        = 3'd2,
    SEND_DATA  = 3'd3,
    WAIT_REPLY = 3'd4
  } seq_state_t;

  // Config register map
  typedef enum logic [1:0]
  {
    CFG_DIV = 2'd0,
    CFG_GAP = 2'd1,
    CFG_TMO = 2'd2,
    CFG_PAR = 2'd3
  } cfg_addr_t;

endpackage

//--- verilog/uart_cfg_regs.sv
`timescale 1ns/100ps
`include "uart_bridge_cfg.svh"

module uart_cfg_regs
  import uart_pkg::*;
  import cmd_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        cfg_wr,
  input  cfg_addr_t   cfg_addr,
  input  logic [15:0] cfg_wdata,
  output logic [15:0] cfg_rdata,
  output logic [15:0] div,
  output logic [7:0]  gap,
  output logic [7:0]  tmo,
  output parity_t     parity
);

  // **************************************************
  // Register writes
  // **************************************************
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      div    <= `DIV_RESET;
      gap    <= `GAP_RESET;
      tmo    <= `TMO_RESET;
      parity <= PAR_ODD;
    end
    else if (cfg_wr)
    begin
      case (cfg_addr)
        CFG_DIV: div    <= cfg_wdata;
        CFG_GAP: gap    <= cfg_wdata[7:0]; // Low byte only
        CFG_TMO: tmo    <= cfg_wdata[7:0];
        CFG_PAR: parity <= parity_t'(cfg_wdata[0]);
      endcase
    end
  end

  // Readback, narrow fields zero-extended
  always_comb
  begin
    case (cfg_addr)
      CFG_DIV: cfg_rdata = div;
      CFG_GAP: cfg_rdata = {8'd0, gap};
      CFG_TMO: cfg_rdata = {8'd0, tmo};
      CFG_PAR: cfg_rdata = {15'd0, parity};
      default: cfg_rdata = 16'd0;
    endcase
  end

endmodule

//--- verilog/uart_tx_frame.sv
`timescale 1ns/100ps

module uart_tx_frame
  import uart_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        start,
  input  logic [7:0]  data,
  input  logic [15:0] div,
  input  parity_t     parity,
  output logic        tx,
  output logic        done
);

  logic         busy;
  frame_phase_t phase;
  logic [15:0]  bcnt;   // Cycles into the current bit
  logic [2:0]   bidx;   // Data bit index
  logic [7:0]   data_q;
  logic         par_q;

  // **************************************************
  // Frame sequencing
  // **************************************************
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy  <= 1'b0;
      phase <= START;
      bcnt  <= 16'd0;
      bidx  <= 3'd0;
      done  <= 1'b0;
    end
    else
    begin
      done <= 1'b0;
      if (!busy)
      begin
        if (start)
        begin
          busy  <= 1'b1;
          phase <= START;
          bcnt  <= 16'd0;
          bidx  <= 3'd0;
        end
      end
      else if (bcnt == div - 16'd1)
      begin
        bcnt <= 16'd0;
        case (phase)
          START:  phase <= DATA;
          DATA:
          begin
            bidx <= bidx + 3'd1;
            if (bidx == 3'd7)
              phase <= PARITY;
          end
          PARITY: phase <= STOP;
          STOP:
          begin
            busy <= 1'b0;
            done <= 1'b1;   // Last cycle of the stop bit on tx
          end
          default: phase <= START;
        endcase
      end
      else
        bcnt <= bcnt + 16'd1;
    end
  end

  // Byte and its parity captured at start
  always_ff @(posedge clk)
  begin
    if (start && !busy)
    begin
      data_q <= data;
      par_q  <= calc_parity(data, parity);
    end
  end

  // Line driver, one cycle behind the phase register
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      tx <= 1'b1;
    else if (!busy)
      tx <= 1'b1;
    else
    begin
      case (phase)
        START:   tx <= 1'b0;
        DATA:    tx <= data_q[bidx];
        PARITY:  tx <= par_q;
        default: tx <= 1'b1;
      endcase
    end
  end

endmodule

//--- verilog/uart_rx_frame.sv
`timescale 1ns/100ps

module uart_rx_frame
  import uart_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        rx,
  input  logic        en,
  input  logic [15:0] div,
  input  parity_t     parity,
  output logic        vld,
  output logic [7:0]  data,
  output logic        bad
);

  logic         rx_meta;
  logic         rx_sync;
  logic         rx_prev;
  logic         fall;
  logic         busy;
  frame_phase_t phase;
  logic [15:0]  bcnt;
  logic [15:0]  half;
  logic [2:0]   bidx;
  logic [7:0]   shreg;
  logic         par_bit;
  logic         sample;
  logic         stop_hit;

  assign fall     = rx_prev & ~rx_sync;
  assign half     = div >> 1;
  assign sample   = busy && (bcnt == half);   // Mid-bit
  assign stop_hit = sample && (phase == STOP);

  // Two-flop synchronizer plus one for edge detect
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  // **************************************************
  // Bit timing and sampling
  // **************************************************
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy  <= 1'b0;
      phase <= START;
      bcnt  <= 16'd0;
      bidx  <= 3'd0;
      vld   <= 1'b0;
      bad   <= 1'b0;
    end
    else
    begin
      vld <= 1'b0;
      if (!en)
        busy <= 1'b0;   // Abandon any partial frame
      else if (!busy)
      begin
        if (fall)
        begin
          busy  <= 1'b1;
          phase <= START;
          bcnt  <= 16'd0;
          bidx  <= 3'd0;
        end
      end
      else
      begin
        bcnt <= (bcnt == div - 16'd1) ? 16'd0 : bcnt + 16'd1;
        if (sample && phase == START && rx_sync)
          busy <= 1'b0;   // Glitch, not a start bit
        if (stop_hit)
        begin
          busy <= 1'b0;
          vld  <= 1'b1;
          bad  <= (par_bit != calc_parity(shreg, parity)) | ~rx_sync;
        end
        if (bcnt == div - 16'd1)
        begin
          case (phase)
            START: phase <= DATA;
            DATA:
            begin
              bidx <= bidx + 3'd1;
              if (bidx == 3'd7)
                phase <= PARITY;
            end
            default: phase <= STOP;
          endcase
        end
      end
    end
  end

  // Received bits, LSB first
  always_ff @(posedge clk)
  begin
    if (sample && phase == DATA)
      shreg <= {rx_sync, shreg[7:1]};
    if (sample && phase == PARITY)
      par_bit <= rx_sync;
    if (stop_hit)
      data <= shreg;
  end

endmodule

//--- verilog/uart_cmd_seq.sv
`timescale 1ns/100ps
`include "uart_bridge_cfg.svh"

module uart_cmd_seq
  import uart_pkg::*;
  import cmd_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [`CMD_WIDTH-1:0] cmd_in,
  input  logic                  cmd_vld,
  input  logic [15:0]           div_cfg,
  input  logic [7:0]            gap_cfg,
  input  logic [7:0]            tmo_cfg,
  input  parity_t               par_cfg,
  input  logic                  tx_done,
  input  logic                  rx_vld,
  input  logic [7:0]            rx_byte,
  input  logic                  rx_bad,
  output logic                  cmd_rdy,
  output logic                  tx_start,
  output logic [7:0]            tx_byte,
  output logic [15:0]           div,
  output parity_t               parity,
  output logic                  rx_en,
  output logic                  rd_done,
  output logic [7:0]            read_data,
  output logic                  rd_err
);

  seq_state_t            state;
  logic [`CMD_WIDTH-1:0] cmd_q;
  logic [7:0]            gap_q;
  logic [7:0]            tmo_q;
  logic [15:0]           bcnt;
  logic [7:0]            bits;   // Whole bit times elapsed
  logic                  accept;
  logic                  gap_hit;
  logic                  tmo_hit;

  assign accept = cmd_vld && cmd_rdy;
  assign rx_en  = (state == WAIT_REPLY);

  // Fire tx_start two cycles early, the transmitter adds two cycles to the start edge
  assign gap_hit = (gap_q == 8'd0) ||
                   (bits == gap_q - 8'd1 && bcnt == div - 16'd3);
  assign tmo_hit = (tmo_q == 8'd0) ||
                   (bits == tmo_q - 8'd1 && bcnt == div - 16'd1);

  // Bit-time counters, running from the end of the address stop bit
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      bcnt <= 16'd0;
      bits <= 8'd0;
    end
    else if (state != GAP && state != WAIT_REPLY)
    begin
      bcnt <= 16'd0;
      bits <= 8'd0;
    end
    else if (bcnt == div - 16'd1)
    begin
      bcnt <= 16'd0;
      bits <= bits + 8'd1;
    end
    else
      bcnt <= bcnt + 16'd1;
  end

  // **************************************************
  // Transaction FSM
  // **************************************************
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= IDLE;
      cmd_rdy  <= 1'b1;
      tx_start <= 1'b0;
      rd_done  <= 1'b0;
      rd_err   <= 1'b0;
      div      <= `DIV_RESET;
      gap_q    <= `GAP_RESET;
      tmo_q    <= `TMO_RESET;
      parity   <= PAR_ODD;
    end
    else
    begin
      tx_start <= 1'b0;
      rd_done  <= 1'b0;
      case (state)
        IDLE:
        begin
          if (accept)
          begin
            state    <= SEND_ADDR;
            cmd_rdy  <= 1'b0;
            tx_start <= 1'b1;
            div      <= div_cfg;   // Config frozen for this command
            gap_q    <= gap_cfg;
            tmo_q    <= tmo_cfg;
            parity   <= par_cfg;
          end
          else
            cmd_rdy <= 1'b1;
        end
        SEND_ADDR:
          if (tx_done)
            state <= cmd_q[CMD_WR_BIT] ? GAP : WAIT_REPLY;
        GAP:
          if (gap_hit)
          begin
            state    <= SEND_DATA;
            tx_start <= 1'b1;
          end
        SEND_DATA:
          if (tx_done)
            state <= IDLE;
        WAIT_REPLY:
        begin
          if (rx_vld)
          begin
            state   <= IDLE;
            rd_done <= 1'b1;
            rd_err  <= rx_bad;
          end
          else if (tmo_hit)
          begin
            state   <= IDLE;
            rd_done <= 1'b1;
            rd_err  <= 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Command word, frame byte and read result
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      cmd_q   <= cmd_in;
      tx_byte <= cmd_in[`CMD_WIDTH-1 -: 8];   // Write flag and address
    end
    else if (state == GAP && gap_hit)
      tx_byte <= cmd_q[7:0];
    if (state == WAIT_REPLY)
    begin
      if (rx_vld)
        read_data <= rx_byte;
      else if (tmo_hit)
        read_data <= 8'd0;
    end
  end

endmodule

//--- verilog/uart_bridge_top.sv
`timescale 1ns/100ps
`include "uart_bridge_cfg.svh"

module uart_bridge_top
  import uart_pkg::*;
  import cmd_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [`CMD_WIDTH-1:0] cmd_in,
  input  logic                  cmd_vld,
  output logic                  cmd_rdy,
  input  logic                  cfg_wr,
  input  cfg_addr_t             cfg_addr,
  input  logic [15:0]           cfg_wdata,
  output logic [15:0]           cfg_rdata,
  input  logic                  rx,
  output logic                  tx,
  output logic                  rd_done,
  output logic [7:0]            read_data,
  output logic                  rd_err
);

  logic [15:0] div_cfg;
  logic [7:0]  gap_cfg;
  logic [7:0]  tmo_cfg;
  parity_t     par_cfg;
  logic [15:0] div_lat;   // Per-command copies from the sequencer
  parity_t     par_lat;
  logic        tx_start;
  logic [7:0]  tx_byte;
  logic        tx_done;
  logic        rx_en;
  logic        rx_vld;
  logic [7:0]  rx_byte;
  logic        rx_bad;

  uart_cfg_regs u_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .cfg_wr    (cfg_wr),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg_rdata (cfg_rdata),
    .div       (div_cfg),
    .gap       (gap_cfg),
    .tmo       (tmo_cfg),
    .parity    (par_cfg)
  );

  uart_cmd_seq u_seq (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .div_cfg   (div_cfg),
    .gap_cfg   (gap_cfg),
    .tmo_cfg   (tmo_cfg),
    .par_cfg   (par_cfg),
    .tx_done   (tx_done),
    .rx_vld    (rx_vld),
    .rx_byte   (rx_byte),
    .rx_bad    (rx_bad),
    .cmd_rdy   (cmd_rdy),
    .tx_start  (tx_start),
    .tx_byte   (tx_byte),
    .div       (div_lat),
    .parity    (par_lat),
    .rx_en     (rx_en),
    .rd_done   (rd_done),
    .read_data (read_data),
    .rd_err    (rd_err)
  );

  uart_tx_frame u_tx (
    .clk    (clk),
    .rst_n  (rst_n),
    .start  (tx_start),
    .data   (tx_byte),
    .div    (div_lat),
    .parity (par_lat),
    .tx     (tx),
    .done   (tx_done)
  );

  uart_rx_frame u_rx (
    .clk    (clk),
    .rst_n  (rst_n),
    .rx     (rx),
    .en     (rx_en),
    .div    (div_lat),
    .parity (par_lat),
    .vld    (rx_vld),
    .data   (rx_byte),
    .bad    (rx_bad)
  );

endmodule

//--- verification/uart_bridge_tb.sv
`timescale 1ns/100ps

module uart_bridge_tb
  import cmd_pkg::*;
();

  logic        clk;
  logic        rst_n;
  logic [15:0] cmd_in;
  logic        cmd_vld;
  logic        cmd_rdy;
  logic        cfg_wr;
  cfg_addr_t   cfg_addr;
  logic [15:0] cfg_wdata;
  logic [15:0] cfg_rdata;
  logic        rx;
  logic        tx;
  logic        rd_done;
  logic [7:0]  read_data;
  logic        rd_err;

  int          seed = 32'h48fc_9e28;
  int          cyc = 0;
  int          frame_cnt = 0;
  int          rd_cnt = 0;
  int          exp_frames;
  int          exp_rd;
  int          fault;            // 0 replies, 1 bad parity, 2 silent
  int          div_sh;           // Programmed config
  int          gap_sh;
  int          tmo_sh;
  logic        par_sh;
  int          div_q;            // Config the current command runs with
  int          gap_q;
  logic        par_q;
  logic [15:0] cmd_q;
  logic [7:0]  mem [128];        // Remote register file
  logic [6:0]  written [$];

  uart_bridge_top uut (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .cfg_wr    (cfg_wr),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg_rdata (cfg_rdata),
    .rx        (rx),
    .tx        (tx),
    .rd_done   (rd_done),
    .read_data (read_data),
    .rd_err    (rd_err)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk)
    cyc <= cyc + 1;

  always @(negedge clk)
    if (rd_done)
      rd_cnt <= rd_cnt + 1;

  // **************************************************
  // Helpers
  // **************************************************
  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic check(input string name, input int act, input int exp);
    if (act != exp)
      fail_now($sformatf("ERR %s got 0x%0h expected 0x%0h", name, act, exp));
  endtask

  function automatic int rnd(input int lo, input int hi);
    int r;
    r = $random(seed);
    return lo + ((r & 32'h7fff_ffff) % (hi - lo + 1));
  endfunction

  task automatic wait_rdy();
    int n;
    n = 0;
    @(negedge clk);
    while (!cmd_rdy)
    begin
      n++;
      if (n > 20000)
        fail_now("Timeout waiting for cmd_rdy to return high");
      @(negedge clk);
    end
  endtask

  task automatic wait_rd_done();
    int n;
    n = 0;
    @(negedge clk);
    while (!rd_done)
    begin
      n++;
      if (n > 20000)
        fail_now("Timeout waiting for rd_done after a read command");
      @(negedge clk);
    end
  endtask

  task automatic set_cfg(input cfg_addr_t a, input int v);
    logic [15:0] w;
    w = 16'($random(seed));   // Junk in the bits a narrow register ignores
    case (a)
      CFG_DIV:
      begin
        w = 16'(v);
        div_sh = v;
      end
      CFG_GAP:
      begin
        w[7:0] = 8'(v);
        gap_sh = v;
      end
      CFG_TMO:
      begin
        w[7:0] = 8'(v);
        tmo_sh = v;
      end
      default:
      begin
        w[0] = v[0];
        par_sh = v[0];
      end
    endcase
    @(posedge clk);
    #2;
    cfg_wr = 1'b1;
    cfg_addr = a;
    cfg_wdata = w;
    @(posedge clk);
    #2;
    cfg_wr = 1'b0;
  endtask

  task automatic read_check(input cfg_addr_t a, input int exp);
    @(posedge clk);
    #2;
    cfg_addr = a;
    @(negedge clk);
    check("cfg_rdata", 32'(cfg_rdata), exp);
  endtask

  task automatic issue_cmd(input logic [15:0] cmd);
    wait_rdy();
    @(posedge clk);
    #2;
    div_q = div_sh;
    gap_q = gap_sh;
    par_q = par_sh;
    cmd_q = cmd;
    cmd_in = cmd;
    cmd_vld = 1'b1;
    exp_frames += cmd[15] ? 2 : 1;
    @(posedge clk);
    #2;
    cmd_vld = 1'b0;
  endtask

  task automatic read_cmd(input logic [6:0] a, input int mode);
    fault = mode;
    issue_cmd({1'b0, a, 8'(rnd(0, 255))});
    exp_rd++;
    wait_rd_done();
    check("rd_err", 32'(rd_err), (mode != 0) ? 1 : 0);
    if (mode == 0)
      check("read_data", 32'(read_data), 32'(mem[a]));
    else if (mode == 2)
      check("read_data", 32'(read_data), 0);
    wait_rdy();
    check("rd_done_count", rd_cnt, exp_rd);
    fault = 0;
  endtask

  // **************************************************
  // Remote device model
  // **************************************************
  task automatic get_frame(output logic [7:0] b, output logic p, output logic s);
    int i;
    repeat (div_q / 2) @(negedge clk);   // Middle of the start bit
    check("tx_start_bit", 32'(tx), 0);
    for (i = 0; i < 8; i++)
    begin
      repeat (div_q) @(negedge clk);
      b[i] = tx;
    end
    repeat (div_q) @(negedge clk);
    p = tx;
    repeat (div_q) @(negedge clk);
    s = tx;
  endtask

  task automatic send_reply(input logic [7:0] v, input logic corrupt);
    logic [10:0] fr;
    int          i;
    fr = {1'b1, ^v ^ par_q ^ corrupt, v, 1'b0};
    // Rest of the address stop bit, then a short random pause
    repeat (div_q / 2 + 2 + rnd(0, 2 * div_q)) @(negedge clk);
    for (i = 0; i < 11; i++)
    begin
      @(posedge clk);
      #2;
      rx = fr[i];
      if (i < 10)
        repeat (div_q - 1) @(posedge clk);
    end
  endtask

  initial
  begin : device
    logic [7:0] b;
    logic       p;
    logic       s;
    int         t0;
    int         t_addr;
    logic       pend_wr;
    rx = 1'b1;
    pend_wr = 1'b0;
    t_addr = 0;
    forever
    begin
      @(negedge clk);
      if (rst_n === 1'b1 && tx === 1'b0)
      begin
        t0 = cyc;
        get_frame(b, p, s);
        check("tx_stop_bit", 32'(s), 1);
        check("tx_parity_ones", 32'(^{b, p}), 32'(par_q));
        frame_cnt++;
        if (pend_wr)
        begin
          check("data_byte", 32'(b), 32'(cmd_q[7:0]));
          check("gap_cycles", t0 - t_addr - 11 * div_q, gap_q * div_q);
          mem[cmd_q[14:8]] = b;
          pend_wr = 1'b0;
        end
        else
        begin
          check("addr_byte", 32'(b), 32'(cmd_q[15:8]));
          t_addr = t0;
          if (b[7])
            pend_wr = 1'b1;
          else if (fault != 2)
            send_reply(mem[b[6:0]], fault == 1);
        end
      end
    end
  end

  // **************************************************
  // Stimulus
  // **************************************************
  initial
  begin : main
    logic [6:0] a;
    int         i;
    rst_n = 1'b0;
    cmd_in = 16'd0;
    cmd_vld = 1'b0;
    cfg_wr = 1'b0;
    cfg_addr = CFG_DIV;
    cfg_wdata = 16'd0;
    fault = 0;
    exp_frames = 0;
    exp_rd = 0;
    div_sh = 434;
    gap_sh = 10;
    tmo_sh = 40;
    par_sh = 1'b1;
    for (i = 0; i < 128; i++)
      mem[i] = 8'(i * 37) ^ 8'h5c;
    repeat (2) @(posedge clk);
    #2;
    rst_n = 1'b1;

    // Reset state and config readback
    @(negedge clk);
    check("tx", 32'(tx), 1);
    check("cmd_rdy", 32'(cmd_rdy), 1);
    check("rd_done", 32'(rd_done), 0);
    read_check(CFG_DIV, 434);
    read_check(CFG_GAP, 10);
    read_check(CFG_TMO, 40);
    read_check(CFG_PAR, 1);
    set_cfg(CFG_DIV, rnd(4, 12));
    set_cfg(CFG_GAP, rnd(1, 15));
    set_cfg(CFG_TMO, rnd(20, 60));
    set_cfg(CFG_PAR, rnd(0, 1));
    read_check(CFG_DIV, div_sh);
    read_check(CFG_GAP, gap_sh);
    read_check(CFG_TMO, tmo_sh);
    read_check(CFG_PAR, 32'(par_sh));

    for (i = 0; i < 60; i++)
    begin
      a = 7'(rnd(0, 127));
      issue_cmd({1'b1, a, 8'(rnd(0, 255))});
      written.push_back(a);
    end
    wait_rdy();

    for (i = 0; i < 20; i++)
      read_cmd(written[rnd(0, written.size() - 1)], 0);
    read_cmd(written[0], 1);   // Reply with inverted parity
    read_cmd(written[1], 2);   // No reply at all

    // Commands and config writes while a write is in flight
    a = 7'(rnd(0, 127));
    issue_cmd({1'b1, a, 8'(rnd(0, 255))});
    for (i = 0; i < 3; i++)
    begin
      @(posedge clk);
      #2;
      cmd_in = 16'($random(seed));
      cmd_vld = 1'b1;
      @(posedge clk);
      #2;
      cmd_vld = 1'b0;
    end
    set_cfg(CFG_DIV, rnd(4, 12));
    set_cfg(CFG_GAP, rnd(1, 15));
    set_cfg(CFG_PAR, par_sh ? 0 : 1);
    read_cmd(a, 0);
    issue_cmd({1'b1, 7'(rnd(0, 127)), 8'(rnd(0, 255))});
    wait_rdy();
    check("frame_count", frame_cnt, exp_frames);

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

//--- uart_bridge.f
+incdir+verilog
verilog/uart_pkg.sv
verilog/cmd_pkg.sv
verilog/uart_cfg_regs.sv
verilog/uart_tx_frame.sv
verilog/uart_rx_frame.sv
verilog/uart_cmd_seq.sv
verilog/uart_bridge_top.sv
verification/uart_bridge_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the bridge and its testbench with Verilator, then run it.
# The exit status is nonzero when the build or the simulation fails.
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/100ps \
  --top-module uart_bridge_tb -f uart_bridge.f -o uart_bridge_sim &&
./obj_dir/uart_bridge_sim || { echo "Simulation failed"; exit 1; }
